// ==== helios_pkg.sv ====
package helios_pkg;

    // global stage of one decoding round, shared by the controller and the array
    typedef enum logic [2:0] {
        stage_idle                = 3'd0,
        stage_measurement_loading = 3'd1,
        stage_growing             = 3'd2,
        stage_merging             = 3'd3,
        stage_peeling             = 3'd4,
        stage_result_valid        = 3'd5
    } stage_t;

    // round bookkeeping
    localparam int iteration_width = 8;
    localparam int cycle_width = 32;

    // syndrome generator
    localparam int lfsr_width = 32;

    // galois form, applied after the right shift when the dropped bit is 1
    localparam logic [lfsr_width-1:0] lfsr_taps = 32'hB4BCD35C;

    // cycles from the last loading cycle to the edge that advances the lfsr
    localparam int update_delay = 4;

    // a boundary message is header, address, then these extra payload bits
    localparam int payload_extra_bits = 9;

endpackage

// ==== stage_controller.sv ====
`timescale 1ns/1ps

module stage_controller #(
    parameter int maximum_initial_delay = 3,
    parameter int maximum_busy_delay = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic start_valid,
    output logic start_ready,
    input  logic busy,
    input  logic odd_clusters,
    output helios_pkg::stage_t stage,
    output logic result_valid,
    output logic [helios_pkg::iteration_width-1:0] iteration_counter,
    output logic [helios_pkg::cycle_width-1:0] cycle_counter
);

    localparam int longest_delay = (maximum_initial_delay > maximum_busy_delay) ?
                                   maximum_initial_delay : maximum_busy_delay;
    localparam int delay_width = $clog2(longest_delay + 1);

    // one counter does both jobs, the loading wait and the busy-low run
    logic [delay_width-1:0] delay_count;
    logic start_fire;
    logic loading_done;
    logic settled;

    assign start_ready = stage == helios_pkg::stage_idle;
    assign start_fire = start_valid && start_ready;
    assign result_valid = stage == helios_pkg::stage_result_valid;

    assign loading_done = delay_count == delay_width'(maximum_initial_delay - 1);

    // busy low in this cycle completes the required run
    assign settled = !busy && delay_count == delay_width'(maximum_busy_delay - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= helios_pkg::stage_idle;
            delay_count <= '0;
            iteration_counter <= '0;
            cycle_counter <= '0;
        end else begin
            // holds through idle so the last round's length stays readable
            if (start_fire) begin
                cycle_counter <= '0;
            end else if (stage != helios_pkg::stage_idle) begin
                cycle_counter <= cycle_counter + helios_pkg::cycle_width'(1);
            end

            case (stage)
                helios_pkg::stage_idle: begin
                    if (start_fire) begin
                        stage <= helios_pkg::stage_measurement_loading;
                        delay_count <= '0;
                        iteration_counter <= '0;
                    end
                end
                helios_pkg::stage_measurement_loading: begin
                    if (loading_done) begin
                        stage <= helios_pkg::stage_growing;
                        delay_count <= '0;
                    end else begin
                        delay_count <= delay_count + delay_width'(1);
                    end
                end
                helios_pkg::stage_growing: begin
                    stage <= helios_pkg::stage_merging;
                    delay_count <= '0;
                end
                helios_pkg::stage_merging: begin
                    if (busy) begin
                        delay_count <= '0;
                    end else if (settled) begin
                        delay_count <= '0;
                        if (odd_clusters) begin
                            stage <= helios_pkg::stage_growing;
                            iteration_counter <= iteration_counter +
                                                 helios_pkg::iteration_width'(1);
                        end else begin
                            stage <= helios_pkg::stage_peeling;
                        end
                    end else begin
                        delay_count <= delay_count + delay_width'(1);
                    end
                end
                helios_pkg::stage_peeling: begin
                    if (busy) begin
                        delay_count <= '0;
                    end else if (settled) begin
                        delay_count <= '0;
                        stage <= helios_pkg::stage_result_valid;
                    end else begin
                        delay_count <= delay_count + delay_width'(1);
                    end
                end
                helios_pkg::stage_result_valid: begin
                    stage <= helios_pkg::stage_idle;
                end
                default: begin
                    stage <= helios_pkg::stage_idle;
                end
            endcase
        end
    end

endmodule

// ==== syndrome_source.sv ====
`timescale 1ns/1ps

module syndrome_source #(
    parameter int pu_count = 18,
    parameter logic [helios_pkg::lfsr_width-1:0] lfsr_seed = 32'h1
) (
    input  logic clk,
    input  logic reset,
    input  helios_pkg::stage_t stage,
    input  logic [15:0] readout_index,
    output logic [pu_count-1:0] measurements,
    output logic readout_bit
);

    localparam int timer_width = $clog2(helios_pkg::update_delay + 1);
    localparam int index_width = (pu_count > 1) ? $clog2(pu_count) : 1;

    logic [helios_pkg::lfsr_width-1:0] lfsr_state;
    logic [timer_width-1:0] update_timer;
    logic advance;
    logic [15:0] index_q;

    // rearmed on every loading cycle, so it only runs out after the last one
    always_ff @(posedge clk) begin
        if (reset) begin
            update_timer <= '0;
        end else if (stage == helios_pkg::stage_measurement_loading) begin
            update_timer <= timer_width'(1);
        end else if (update_timer != '0 && !advance) begin
            update_timer <= update_timer + timer_width'(1);
        end else begin
            update_timer <= '0;
        end
    end

    assign advance = update_timer == timer_width'(helios_pkg::update_delay);

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr_state <= lfsr_seed;
        end else if (advance) begin
            if (lfsr_state[0]) begin
                lfsr_state <= (lfsr_state >> 1) ^ helios_pkg::lfsr_taps;
            end else begin
                lfsr_state <= lfsr_state >> 1;
            end
        end
    end

    // one measurement per processing unit
    assign measurements = lfsr_state[pu_count-1:0];

    // debug line, index register then bit register
    always_ff @(posedge clk) begin
        index_q <= readout_index;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readout_bit <= 1'b0;
        end else if (index_q < 16'(pu_count)) begin
            readout_bit <= measurements[index_q[index_width-1:0]];
        end
    end

endmodule

// ==== boundary_fifo.sv ====
`timescale 1ns/1ps

module boundary_fifo #(
    parameter int payload_width = 15,
    parameter int header_width = 3,
    parameter int header_id = 0
) (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    input  logic [payload_width-1:0] in_payload,
    output logic head_valid,
    output logic [header_width+payload_width-1:0] head_message,
    input  logic head_pop
);

    logic [payload_width-1:0] entries [2];
    logic wr_ptr;
    logic rd_ptr;
    logic [1:0] count;
    logic push;
    logic pop;

    assign in_ready = count != 2'd2;
    assign head_valid = count != 2'd0;
    assign push = in_valid && in_ready;
    assign pop = head_pop && head_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_payload;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            if (push && !pop) begin
                count <= count + 2'd1;
            end else if (pop && !push) begin
                count <= count - 2'd1;
            end
        end
    end

    // the other half routes on the header, so each slot stamps its own
    assign head_message = {header_width'(header_id), entries[rd_ptr]};

endmodule

// ==== message_arbiter.sv ====
`timescale 1ns/1ps

module message_arbiter #(
    parameter int slot_count = 6,
    parameter int message_width = 18
) (
    input  logic clk,
    input  logic reset,
    input  logic [slot_count-1:0] head_valid,
    input  logic [slot_count*message_width-1:0] head_message,
    output logic [slot_count-1:0] head_pop,
    output logic link_valid,
    input  logic link_ready,
    output logic [message_width-1:0] link_data
);

    localparam int ptr_width = (slot_count > 1) ? $clog2(slot_count) : 1;

    logic [ptr_width-1:0] rr_ptr;
    logic [ptr_width-1:0] pick;
    logic [ptr_width-1:0] grant;
    logic [ptr_width-1:0] locked_grant;
    logic locked;
    logic found;
    logic transfer;

    // first valid slot at or after the round-robin pointer
    always_comb begin
        int idx;
        pick = '0;
        found = 1'b0;
        for (int offset = 0; offset < slot_count; offset++) begin
            idx = (int'(rr_ptr) + offset) % slot_count;
            if (!found && head_valid[idx]) begin
                found = 1'b1;
                pick = ptr_width'(idx);
            end
        end
    end

    // a stalled message keeps its slot until the link takes it
    assign grant = locked ? locked_grant : pick;
    assign link_valid = locked || found;
    assign link_data = head_message[int'(grant)*message_width +: message_width];
    assign transfer = link_valid && link_ready;

    always_comb begin
        head_pop = '0;
        if (transfer) begin
            head_pop[grant] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
            locked <= 1'b0;
            locked_grant <= '0;
        end else if (transfer) begin
            locked <= 1'b0;
            rr_ptr <= (grant == ptr_width'(slot_count - 1)) ? '0 : grant + ptr_width'(1);
        end else if (link_valid) begin
            locked <= 1'b1;
            locked_grant <= grant;
        end
    end

endmodule

// ==== helios_left_top.sv ====
`timescale 1ns/1ps

module helios_left_top #(
    parameter int code_distance_x = 3,
    parameter int code_distance_z = 2,
    parameter int maximum_initial_delay = 3,
    parameter int maximum_busy_delay = 2,
    parameter logic [helios_pkg::lfsr_width-1:0] lfsr_seed = 32'h1,
    localparam int measurement_rounds = (code_distance_x > code_distance_z) ?
                                        code_distance_x : code_distance_z,
    localparam int pu_count = code_distance_x * code_distance_z * measurement_rounds,
    localparam int per_dim_bit_width = $clog2(measurement_rounds),
    localparam int address_width = per_dim_bit_width * 3,
    // one boundary slot per column along z in every measurement round
    localparam int slot_count = code_distance_z * measurement_rounds,
    localparam int header_width = $clog2(slot_count + 1),
    localparam int payload_width = address_width + helios_pkg::payload_extra_bits,
    localparam int message_width = header_width + payload_width
) (
    input  logic clk,
    input  logic reset,
    input  logic start_valid,
    output logic start_ready,
    input  logic busy,
    input  logic odd_clusters,
    output helios_pkg::stage_t stage,
    output logic result_valid,
    output logic [helios_pkg::iteration_width-1:0] iteration_counter,
    output logic [helios_pkg::cycle_width-1:0] cycle_counter,
    output logic [pu_count-1:0] measurements,
    input  logic [15:0] readout_index,
    output logic readout_bit,
    input  logic [slot_count-1:0] boundary_valid,
    output logic [slot_count-1:0] boundary_ready,
    input  logic [slot_count*payload_width-1:0] boundary_payload,
    output logic link_valid,
    input  logic link_ready,
    output logic [message_width-1:0] link_data
);

    logic [slot_count-1:0] head_valid;
    logic [slot_count*message_width-1:0] head_message;
    logic [slot_count-1:0] head_pop;

    // measurements come straight out of the lfsr
    if (pu_count > helios_pkg::lfsr_width) begin : g_pu_count_check
        $error("pu count exceeds the LFSR width");
    end

    stage_controller #(
        .maximum_initial_delay(maximum_initial_delay),
        .maximum_busy_delay(maximum_busy_delay)
    ) controller_inst (
        .clk(clk),
        .reset(reset),
        .start_valid(start_valid),
        .start_ready(start_ready),
        .busy(busy),
        .odd_clusters(odd_clusters),
        .stage(stage),
        .result_valid(result_valid),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter)
    );

    syndrome_source #(
        .pu_count(pu_count),
        .lfsr_seed(lfsr_seed)
    ) syndrome_inst (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .readout_index(readout_index),
        .measurements(measurements),
        .readout_bit(readout_bit)
    );

    for (genvar s = 0; s < slot_count; s++) begin : g_slot
        boundary_fifo #(
            .payload_width(payload_width),
            .header_width(header_width),
            .header_id(s)
        ) fifo_inst (
            .clk(clk),
            .reset(reset),
            .in_valid(boundary_valid[s]),
            .in_ready(boundary_ready[s]),
            .in_payload(boundary_payload[s*payload_width +: payload_width]),
            .head_valid(head_valid[s]),
            .head_message(head_message[s*message_width +: message_width]),
            .head_pop(head_pop[s])
        );
    end

    message_arbiter #(
        .slot_count(slot_count),
        .message_width(message_width)
    ) arbiter_inst (
        .clk(clk),
        .reset(reset),
        .head_valid(head_valid),
        .head_message(head_message),
        .head_pop(head_pop),
        .link_valid(link_valid),
        .link_ready(link_ready),
        .link_data(link_data)
    );

endmodule

// ==== helios_left_asserts.sv ====
`timescale 1ns/1ps

module helios_left_asserts #(
    parameter int message_width = 18
) (
    input logic clk,
    input logic reset,
    input helios_pkg::stage_t stage,
    input logic start_valid,
    input logic start_ready,
    input logic result_valid,
    input logic link_valid,
    input logic link_ready,
    input logic [message_width-1:0] link_data
);

    // a stalled message waits on the link unchanged
    link_held: assert property (
        @(posedge clk) disable iff (reset)
        link_valid && !link_ready |=> link_valid && $stable(link_data)
    ) else $error("link_data changed while the link was stalled");

    // the result stage lasts one cycle, then the round is over
    result_in_stage: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |-> stage == helios_pkg::stage_result_valid
                         ##1 stage == helios_pkg::stage_idle
    ) else $error("result_valid not a single cycle followed by idle");

    start_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        start_valid && start_ready |-> stage == helios_pkg::stage_idle
                                       ##1 stage == helios_pkg::stage_measurement_loading
    ) else $error("start handshake outside idle or not followed by loading");

endmodule

bind helios_left_top helios_left_asserts #(
    .message_width(message_width)
) asserts_inst (
    .clk(clk),
    .reset(reset),
    .stage(stage),
    .start_valid(start_valid),
    .start_ready(start_ready),
    .result_valid(result_valid),
    .link_valid(link_valid),
    .link_ready(link_ready),
    .link_data(link_data)
);

// ==== tb_helios_left.sv ====
`timescale 1ns/1ps

module tb_helios_left;

    localparam int maximum_initial_delay = 3;
    localparam int maximum_busy_delay = 2;
    // geometry of the default top level, distance x 3 and distance z 2
    localparam int pu_count = 18;
    localparam int slot_count = 6;
    localparam int header_width = 3;
    localparam int payload_width = 15;
    localparam int message_width = header_width + payload_width;
    localparam int clock_period = 20;

    // each row gives odd merges, busy pulse per merge and readout indices
    localparam int row_count = 6;
    localparam int max_pulse = 4;
    localparam int odd_merges [row_count] = '{0, 1, 2, 0, 3, 1};
    localparam int merge_pulse [row_count][4] = '{
        '{0, 0, 0, 0}, '{2, 0, 0, 0}, '{1, 3, 0, 0},
        '{4, 0, 0, 0}, '{0, 1, 2, 1}, '{3, 2, 0, 0}
    };
    localparam logic [15:0] readout_list [row_count][4] = '{
        '{16'd0, 16'd5, 16'd17, 16'd18}, '{16'd3, 16'd30, 16'd9, 16'd12},
        '{16'hffff, 16'd1, 16'd2, 16'd7}, '{16'd17, 16'd16, 16'd20, 16'd4},
        '{16'd11, 16'd13, 16'd100, 16'd6}, '{16'd8, 16'd18, 16'd0, 16'd15}
    };
    localparam int round_bound = 3 + maximum_initial_delay +
                                 4 * (1 + max_pulse + maximum_busy_delay) +
                                 max_pulse + maximum_busy_delay + 2;

    logic clk;
    logic reset;
    logic start_valid;
    logic start_ready;
    logic busy;
    logic odd_clusters;
    logic result_valid;
    helios_pkg::stage_t stage;
    logic [helios_pkg::iteration_width-1:0] iteration_counter;
    logic [helios_pkg::cycle_width-1:0] cycle_counter;
    logic [pu_count-1:0] measurements;
    logic [15:0] readout_index;
    logic readout_bit;
    logic [slot_count-1:0] boundary_valid;
    logic [slot_count-1:0] boundary_ready;
    logic [slot_count-1:0] p_boundary_ready;
    logic [slot_count*payload_width-1:0] boundary_payload;
    logic link_valid;
    logic link_ready;
    logic p_link_valid;
    logic [message_width-1:0] link_data;
    logic [message_width-1:0] p_link_data;

    // reference state
    helios_pkg::stage_t m_stage;
    int m_iteration;
    int round_cycles;
    int loading_left;
    int low_run;
    int update_wait;
    logic [31:0] m_lfsr;
    logic [15:0] m_index;
    logic m_readout;
    logic [message_width-1:0] pending [$];
    int delivered;
    int row;
    int merge_index;
    int stage_age;
    int tick_count;
    bit offer_enable;
    integer seed = 32'h7689dd26;

    helios_left_top helios_left_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(clock_period / 2) clk = ~clk;
    end

    initial begin
        #((row_count * round_bound + 400) * clock_period);
        $display("simulation hung, no finish after %0d cycles", row_count * round_bound + 400);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ helios_pkg::lfsr_taps : state >> 1;
    endfunction

    // entries a slot's FIFO should hold, accepted but not yet on the link
    function automatic int slot_occupancy(input int slot);
        int n;
        n = 0;
        foreach (pending[i]) begin
            if (pending[i][message_width-1 -: header_width] == header_width'(slot))
                n++;
        end
        return n;
    endfunction

    task automatic compare_outputs();
        check("stage", 64'(stage), 64'(m_stage));
        check("start_ready", 64'(start_ready), 64'(m_stage == helios_pkg::stage_idle));
        check("result_valid", 64'(result_valid),
              64'(m_stage == helios_pkg::stage_result_valid));
        check("iteration_counter", 64'(iteration_counter), 64'(m_iteration));
        check("cycle_counter", 64'(cycle_counter), 64'(round_cycles));
        check("measurements", 64'(measurements), 64'(m_lfsr[pu_count-1:0]));
        check("readout_bit", 64'(readout_bit), 64'(m_readout));
        for (int s = 0; s < slot_count; s++) begin
            check($sformatf("boundary_ready[%0d]", s), 64'(boundary_ready[s]),
                  64'(slot_occupancy(s) < 2));
        end
        check("link_valid", 64'(link_valid), 64'(pending.size() != 0));
    endtask

    task automatic drive_inputs();
        int pulse;
        pulse = merge_pulse[row % row_count][merge_index % 4];
        if (m_stage == helios_pkg::stage_peeling)
            pulse = merge_pulse[row % row_count][0];
        if (m_stage != helios_pkg::stage_idle)
            start_valid = 1'b0;
        busy = 1'($random(seed));
        odd_clusters = 1'($random(seed));
        if (m_stage == helios_pkg::stage_merging || m_stage == helios_pkg::stage_peeling)
            busy = stage_age < pulse;
        if (m_stage == helios_pkg::stage_merging)
            odd_clusters = merge_index < odd_merges[row % row_count];
        readout_index = readout_list[row % row_count][tick_count % 4];
        for (int s = 0; s < slot_count; s++) begin
            if (boundary_valid[s] && p_boundary_ready[s])
                boundary_valid[s] = 1'b0;
            if (!boundary_valid[s] && offer_enable && ($random(seed) & 3) == 0) begin
                boundary_valid[s] = 1'b1;
                boundary_payload[s*payload_width +: payload_width] = payload_width'($random(seed));
            end
        end
        link_ready = ($random(seed) & 3) != 0;
    endtask

    task automatic tick();
        helios_pkg::stage_t prev_stage;
        bit found;
        // outputs as the coming edge sees them
        @(negedge clk);
        p_boundary_ready = boundary_ready;
        p_link_valid = link_valid;
        p_link_data = link_data;
        @(posedge clk);
        #2;
        prev_stage = m_stage;
        if (prev_stage != helios_pkg::stage_idle)
            round_cycles++;
        case (m_stage)
            helios_pkg::stage_idle: begin
                if (start_valid) begin
                    m_stage = helios_pkg::stage_measurement_loading;
                    m_iteration = 0;
                    round_cycles = 0;
                    merge_index = 0;
                    loading_left = maximum_initial_delay;
                end
            end
            helios_pkg::stage_measurement_loading: begin
                loading_left--;
                if (loading_left == 0)
                    m_stage = helios_pkg::stage_growing;
            end
            helios_pkg::stage_growing: m_stage = helios_pkg::stage_merging;
            helios_pkg::stage_merging, helios_pkg::stage_peeling: begin
                low_run = busy ? 0 : low_run + 1;
                if (low_run == maximum_busy_delay) begin
                    low_run = 0;
                    if (m_stage == helios_pkg::stage_peeling) begin
                        m_stage = helios_pkg::stage_result_valid;
                    end else if (odd_clusters) begin
                        m_stage = helios_pkg::stage_growing;
                        m_iteration++;
                    end else begin
                        m_stage = helios_pkg::stage_peeling;
                    end
                end
            end
            default: m_stage = helios_pkg::stage_idle;
        endcase
        // readout sees the measurements from before the edge
        if (m_index < pu_count)
            m_readout = m_lfsr[m_index[4:0]];
        m_index = readout_index;
        if (prev_stage == helios_pkg::stage_measurement_loading) begin
            update_wait = helios_pkg::update_delay;
        end else if (update_wait > 0) begin
            update_wait--;
            if (update_wait == 0)
                m_lfsr = next_lfsr(m_lfsr);
        end
        // a payload taken at this edge cannot leave on the same edge
        if (p_link_valid && link_ready) begin
            found = 1'b0;
            // oldest pending message with the same header is the one owed
            for (int i = 0; i < pending.size(); i++) begin
                if (!found && pending[i][message_width-1 -: header_width] ==
                              p_link_data[message_width-1 -: header_width]) begin
                    check("link_data", 64'(p_link_data), 64'(pending[i]));
                    pending.delete(i);
                    found = 1'b1;
                end
            end
            if (!found) begin
                $display("link carried a message for slot %0d that no FIFO was holding",
                         p_link_data[message_width-1 -: header_width]);
                $display("Done: errors found");
                $fatal(1, "unexpected link message");
            end
            delivered++;
        end else if (p_link_valid) begin
            check("link_valid", 64'(link_valid), 64'(1));
            check("link_data", 64'(link_data), 64'(p_link_data));
        end
        for (int s = 0; s < slot_count; s++) begin
            if (boundary_valid[s] && p_boundary_ready[s]) begin
                pending.push_back({header_width'(s),
                                   boundary_payload[s*payload_width +: payload_width]});
            end
        end
        compare_outputs();
        stage_age = (m_stage == prev_stage) ? stage_age + 1 : 0;
        if (prev_stage == helios_pkg::stage_merging && m_stage != helios_pkg::stage_merging)
            merge_index++;
        tick_count++;
        drive_inputs();
    endtask

    initial begin
        reset = 1'b1;
        start_valid = 1'b0;
        busy = 1'b0;
        odd_clusters = 1'b0;
        link_ready = 1'b0;
        readout_index = '0;
        boundary_valid = '0;
        boundary_payload = '0;
        m_stage = helios_pkg::stage_idle;
        m_lfsr = 32'h1;
        m_index = '0;
        m_readout = 1'b0;
        offer_enable = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        compare_outputs();
        check("link_valid", 64'(link_valid), 64'(0));
        for (row = 0; row < row_count; row++) begin
            repeat (2) tick();
            start_valid = 1'b1;
            while (m_stage == helios_pkg::stage_idle)
                tick();
            while (m_stage != helios_pkg::stage_result_valid)
                tick();
            check("iteration_counter", 64'(iteration_counter), 64'(odd_merges[row]));
            check("cycle_counter", 64'(cycle_counter), 64'(round_cycles));
            tick();
        end
        // let every accepted payload leave before the final check
        offer_enable = 1'b0;
        while (boundary_valid != '0 || pending.size() != 0)
            tick();
        repeat (8) tick();
        check("link_valid", 64'(link_valid), 64'(0));
        if (delivered == 0) begin
            $display("no boundary message ever reached the link");
            $display("Done: errors found");
            $fatal(1, "boundary path never carried a message");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
helios_pkg.sv
stage_controller.sv
syndrome_source.sv
boundary_fifo.sv
message_arbiter.sv
helios_left_top.sv
helios_left_asserts.sv
tb_helios_left.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_helios_left
FILELIST = tb.f
OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
